//--- run_sim.sh
#!/bin/sh
# Build and run the melody game testbench with Verilator

verilator --binary --timing --top-module tb_melody_game -f sim.f -o tb_melody_game \
    && ./obj_dir/tb_melody_game > sim.log 2>&1 ; \
    cat sim.log \
    && grep -q "^Simulation passed$" sim.log \
    || { echo "Run did not pass, see sim.log"; exit 1; }

//--- sim.f
src/game_pkg.sv
src/note_pkg.sv
src/hex_display.sv
src/note_player.sv
src/press_meter.sv
src/game_datapath.sv
src/game_control.sv
src/melody_game.sv
testbench/tb_melody_game.sv

//--- src/game_control.sv
`timescale 1ns/1ps
`default_nettype none

module game_control import game_pkg::*; (
    input  wire        clock,
    input  wire        reset,
    input  wire        iniciar,
    input  wire        tentar_dnv,
    input  wire        play_done,
    input  wire        last_addr,
    input  wire        last_round,
    input  wire        press_done,
    input  wire        note_ok,
    input  wire        timing_ok,
    input  wire        timed_out,
    output logic       clear_round,
    output logic       inc_round,
    output logic       clear_addr,
    output logic       inc_addr,
    output logic       clear_timer,
    output logic       play_start,
    output logic       listen,
    output logic       ganhou,
    output logic       perdeu,
    output logic       vez_jogador,
    output logic [3:0] db_state
);

    state_t state;
    state_t state_n;
    logic   clear_round_n;
    logic   inc_round_n;
    logic   clear_addr_n;
    logic   inc_addr_n;
    logic   clear_timer_n;
    logic   play_start_n;

    always_comb begin
        state_n       = state;
        clear_round_n = 1'b0;
        inc_round_n   = 1'b0;
        clear_addr_n  = 1'b0;
        inc_addr_n    = 1'b0;
        clear_timer_n = 1'b0;
        play_start_n  = 1'b0;
        case (state)
            st_idle, st_won: begin
                if (iniciar) begin
                    state_n       = st_load;
                    clear_round_n = 1'b1;
                    clear_addr_n  = 1'b1;
                end
            end
            st_lost: begin
                if (iniciar) begin
                    state_n       = st_load;
                    clear_round_n = 1'b1;
                    clear_addr_n  = 1'b1;
                end else if (tentar_dnv) begin
                    // Same round again
                    state_n      = st_load;
                    clear_addr_n = 1'b1;
                end
            end
            st_load, st_next_play: begin
                state_n      = st_play;
                play_start_n = 1'b1;
            end
            st_play: state_n = st_wait_play;
            st_wait_play: begin
                if (play_done) begin
                    if (last_addr) begin
                        state_n       = st_turn;
                        clear_addr_n  = 1'b1;
                        clear_timer_n = 1'b1;
                    end else begin
                        state_n    = st_next_play;
                        inc_addr_n = 1'b1;
                    end
                end
            end
            st_turn: begin
                if (timed_out) begin
                    state_n       = st_lost;
                    clear_timer_n = 1'b1;
                end else if (press_done) begin
                    state_n       = st_judge;
                    clear_timer_n = 1'b1;
                end
            end
            st_judge: begin
                if (!(note_ok && timing_ok)) begin
                    state_n = st_lost;
                end else if (!last_addr) begin
                    state_n    = st_next_note;
                    inc_addr_n = 1'b1;
                end else if (last_round) begin
                    state_n = st_won;
                end else begin
                    state_n       = st_next_round;
                    inc_round_n   = 1'b1;
                    clear_addr_n  = 1'b1;
                    clear_timer_n = 1'b1;
                end
            end
            st_next_note: state_n = st_turn;
            st_next_round: begin
                // Timer runs the short pause here
                if (timed_out) begin
                    state_n      = st_play;
                    play_start_n = 1'b1;
                end
            end
            default: state_n = st_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= st_idle;
            clear_round <= 1'b0;
            inc_round   <= 1'b0;
            clear_addr  <= 1'b0;
            inc_addr    <= 1'b0;
            clear_timer <= 1'b0;
            play_start  <= 1'b0;
            listen      <= 1'b0;
            ganhou      <= 1'b0;
            perdeu      <= 1'b0;
        end else begin
            state       <= state_n;
            clear_round <= clear_round_n;
            inc_round   <= inc_round_n;
            clear_addr  <= clear_addr_n;
            inc_addr    <= inc_addr_n;
            clear_timer <= clear_timer_n;
            play_start  <= play_start_n;
            listen      <= (state_n == st_turn) || (state_n == st_judge) ||
                           (state_n == st_next_note);
            ganhou      <= (state_n == st_won);
            perdeu      <= (state_n == st_lost);
        end
    end

    assign vez_jogador = listen;
    assign db_state    = state;

endmodule

`default_nettype wire

//--- src/game_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module game_datapath import game_pkg::*, note_pkg::*; (
    input  wire         clock,
    input  wire         reset,
    input  wire  [11:0] botoes,
    input  wire         clear_round,
    input  wire         inc_round,
    input  wire         clear_addr,
    input  wire         inc_addr,
    input  wire         clear_timer,
    input  wire         play_start,
    input  wire         listen,
    output logic        play_done,
    output logic        last_addr,
    output logic        last_round,
    output logic        press_done,
    output logic        note_ok,
    output logic        timing_ok,
    output logic        timed_out,
    output logic [11:0] leds,
    output logic        pulso_buzzer,
    output logic [3:0]  db_round,
    output logic [3:0]  db_addr,
    output logic [3:0]  db_note
);

    logic [round_w-1:0] round_q;
    logic [round_w-1:0] addr_q;
    logic [7:0]         timer_q;
    logic [7:0]         timer_limit;
    note_t              cur_note;
    dur_t               cur_dur;
    logic               press_begin;

    always_ff @(posedge clock) begin
        if (reset) begin
            round_q <= '0;
        end else if (clear_round) begin
            // First round
            round_q <= round_w'(1);
        end else if (inc_round) begin
            round_q <= round_q + round_w'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear_addr) begin
            addr_q <= '0;
        end else if (inc_addr) begin
            addr_q <= addr_q + round_w'(1);
        end
    end

    assign cur_note = melody_note[addr_q[2:0]];
    assign cur_dur  = melody_dur[addr_q[2:0]];

    assign last_addr  = (addr_q == round_q - round_w'(1));
    assign last_round = (round_q == round_w'(num_rounds));

    // Turn timeout while listening, pause between rounds otherwise
    assign timer_limit = listen ? 8'(timeout_cycles) : 8'(gap_cycles);
    assign timed_out   = (timer_q >= timer_limit);

    always_ff @(posedge clock) begin
        if (reset || clear_timer || press_begin) begin
            timer_q <= '0;
        end else if (!timed_out) begin
            timer_q <= timer_q + 8'd1;
        end
    end

    note_player player (
        .clock        ( clock        ),
        .reset        ( reset        ),
        .play_start   ( play_start   ),
        .note         ( cur_note     ),
        .dur          ( cur_dur      ),
        .leds         ( leds         ),
        .pulso_buzzer ( pulso_buzzer ),
        .play_done    ( play_done    )
    );

    press_meter meter (
        .clock         ( clock       ),
        .reset         ( reset       ),
        .listen        ( listen      ),
        .botoes        ( botoes      ),
        .expected_note ( cur_note    ),
        .expected_dur  ( cur_dur     ),
        .press_begin   ( press_begin ),
        .press_done    ( press_done  ),
        .note_ok       ( note_ok     ),
        .timing_ok     ( timing_ok   ),
        .pressed_note  ( db_note     )
    );

    assign db_round = round_q;
    assign db_addr  = addr_q;

endmodule

`default_nettype wire

//--- src/game_pkg.sv
`default_nettype none

package game_pkg;

    // Rounds needed to win
    localparam int num_rounds = 8;

    // Timing, in clock cycles (scaled down for simulation)
    localparam int beat_cycles    = 16;
    localparam int tol_cycles     = 4;
    localparam int gap_cycles     = 4;
    localparam int timeout_cycles = 200;

    localparam int round_w = 4;

    typedef enum logic [3:0] {
        st_idle,
        st_load,
        st_play,
        st_wait_play,
        st_next_play,
        st_turn,
        st_judge,
        st_next_note,
        st_next_round,
        st_won,
        st_lost
    } state_t;

endpackage

`default_nettype wire

//--- src/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display (
    input  wire  [3:0] hexa,
    output logic [6:0] display
);

    // Segments gfedcba, high is lit
    always_comb begin
        case (hexa)
            4'h0: display = 7'h3f;
            4'h1: display = 7'h06;
            4'h2: display = 7'h5b;
            4'h3: display = 7'h4f;
            4'h4: display = 7'h66;
            4'h5: display = 7'h6d;
            4'h6: display = 7'h7d;
            4'h7: display = 7'h07;
            4'h8: display = 7'h7f;
            4'h9: display = 7'h6f;
            4'ha: display = 7'h77;
            4'hb: display = 7'h7c;
            4'hc: display = 7'h39;
            4'hd: display = 7'h5e;
            4'he: display = 7'h79;
            default: display = 7'h71;
        endcase
    end

endmodule

`default_nettype wire

//--- src/melody_game.sv
`timescale 1ns/1ps
`default_nettype none

module melody_game (
    input  wire         clock,
    input  wire         reset,
    input  wire         iniciar,
    input  wire         tentar_dnv,
    input  wire  [11:0] botoes,
    output logic        ganhou,
    output logic        perdeu,
    output logic        vez_jogador,
    output logic [11:0] leds,
    output logic        pulso_buzzer,
    output logic [6:0]  db_round,
    output logic [6:0]  db_state,
    output logic [6:0]  db_note
);

    // Control commands
    logic clear_round, inc_round, clear_addr, inc_addr, clear_timer;
    logic play_start, listen;
    // Conditions
    logic play_done, last_addr, last_round, press_done;
    logic note_ok, timing_ok, timed_out;
    // Display digits
    logic [3:0] s_db_round, s_db_state, s_db_note;

    game_datapath datapath (
        .clock        ( clock        ),
        .reset        ( reset        ),
        .botoes       ( botoes       ),
        .clear_round  ( clear_round  ),
        .inc_round    ( inc_round    ),
        .clear_addr   ( clear_addr   ),
        .inc_addr     ( inc_addr     ),
        .clear_timer  ( clear_timer  ),
        .play_start   ( play_start   ),
        .listen       ( listen       ),
        .play_done    ( play_done    ),
        .last_addr    ( last_addr    ),
        .last_round   ( last_round   ),
        .press_done   ( press_done   ),
        .note_ok      ( note_ok      ),
        .timing_ok    ( timing_ok    ),
        .timed_out    ( timed_out    ),
        .leds         ( leds         ),
        .pulso_buzzer ( pulso_buzzer ),
        .db_round     ( s_db_round   ),
        .db_addr      (              ),
        .db_note      ( s_db_note    )
    );

    game_control control (
        .clock       ( clock       ),
        .reset       ( reset       ),
        .iniciar     ( iniciar     ),
        .tentar_dnv  ( tentar_dnv  ),
        .play_done   ( play_done   ),
        .last_addr   ( last_addr   ),
        .last_round  ( last_round  ),
        .press_done  ( press_done  ),
        .note_ok     ( note_ok     ),
        .timing_ok   ( timing_ok   ),
        .timed_out   ( timed_out   ),
        .clear_round ( clear_round ),
        .inc_round   ( inc_round   ),
        .clear_addr  ( clear_addr  ),
        .inc_addr    ( inc_addr    ),
        .clear_timer ( clear_timer ),
        .play_start  ( play_start  ),
        .listen      ( listen      ),
        .ganhou      ( ganhou      ),
        .perdeu      ( perdeu      ),
        .vez_jogador ( vez_jogador ),
        .db_state    ( s_db_state  )
    );

    hex_display display_round (
        .hexa    ( s_db_round ),
        .display ( db_round   )
    );

    hex_display display_state (
        .hexa    ( s_db_state ),
        .display ( db_state   )
    );

    hex_display display_note (
        .hexa    ( s_db_note ),
        .display ( db_note   )
    );

endmodule

`default_nettype wire

//--- src/note_pkg.sv
`default_nettype none

package note_pkg;

    localparam int num_notes = 12;

    // Index of the button, LED and pitch
    typedef logic [3:0] note_t;

    // Length in beats, 1 to 3
    typedef logic [1:0] dur_t;

    // Buzzer half-periods in cycles, lowest pitch first
    localparam logic [7:0] half_period [num_notes] = '{
        8'd20, 8'd19, 8'd18, 8'd17,
        8'd16, 8'd15, 8'd14, 8'd13,
        8'd12, 8'd11, 8'd10, 8'd9
    };

    // Opening phrase of Ode to Joy, C major from note 0
    localparam note_t melody_note [8] = '{
        4'd4, 4'd4, 4'd5, 4'd7,
        4'd7, 4'd5, 4'd4, 4'd2
    };

    localparam dur_t melody_dur [8] = '{
        2'd1, 2'd1, 2'd1, 2'd1,
        2'd1, 2'd1, 2'd2, 2'd3
    };

endpackage

`default_nettype wire

//--- src/note_player.sv
`timescale 1ns/1ps
`default_nettype none

module note_player import game_pkg::*, note_pkg::*; (
    input  wire         clock,
    input  wire         reset,
    input  wire         play_start,
    input  wire note_t  note,
    input  wire dur_t   dur,
    output logic [11:0] leds,
    output logic        pulso_buzzer,
    output logic        play_done
);

    note_t      note_q;
    logic [7:0] lit_len;
    logic [7:0] cnt;
    logic [7:0] tone_cnt;
    logic       lit;
    logic       dark;
    logic       buzz;

    always_ff @(posedge clock) begin
        if (play_start) begin
            note_q  <= note;
            lit_len <= 8'(dur) * 8'(beat_cycles);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lit       <= 1'b0;
            dark      <= 1'b0;
            cnt       <= '0;
            tone_cnt  <= '0;
            buzz      <= 1'b0;
            play_done <= 1'b0;
        end else begin
            play_done <= 1'b0;
            if (play_start) begin
                lit      <= 1'b1;
                dark     <= 1'b0;
                cnt      <= '0;
                tone_cnt <= '0;
                // Buzzer goes high on the first lit cycle
                buzz     <= 1'b1;
            end else if (lit) begin
                if (tone_cnt == half_period[note_q] - 8'd1) begin
                    tone_cnt <= '0;
                    buzz     <= ~buzz;
                end else begin
                    tone_cnt <= tone_cnt + 8'd1;
                end
                if (cnt == lit_len - 8'd1) begin
                    lit  <= 1'b0;
                    dark <= 1'b1;
                    cnt  <= '0;
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end else if (dark) begin
                if (cnt == 8'(gap_cycles - 1)) begin
                    dark      <= 1'b0;
                    play_done <= 1'b1;
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end
        end
    end

    assign leds         = lit ? (12'd1 << note_q) : 12'd0;
    assign pulso_buzzer = lit & buzz;

endmodule

`default_nettype wire

//--- src/press_meter.sv
`timescale 1ns/1ps
`default_nettype none

module press_meter import game_pkg::*, note_pkg::*; (
    input  wire         clock,
    input  wire         reset,
    input  wire         listen,
    input  wire  [11:0] botoes,
    input  wire note_t  expected_note,
    input  wire dur_t   expected_dur,
    output logic        press_begin,
    output logic        press_done,
    output logic        note_ok,
    output logic        timing_ok,
    output logic [3:0]  pressed_note
);

    logic [11:0] botoes_q;
    logic [11:0] first_q;
    logic [11:0] expected_onehot;
    logic [7:0]  hold;
    logic [7:0]  target;
    logic [3:0]  lowest;
    logic        active;
    logic        varied;

    assign expected_onehot = 12'd1 << expected_note;
    assign target          = 8'(expected_dur) * 8'(beat_cycles);
    assign press_begin     = listen && !active && (botoes_q != 12'd0);

    // Lowest set button wins
    always_comb begin
        lowest = 4'd0;
        for (int i = 11; i >= 0; i--) begin
            if (botoes_q[i]) begin
                lowest = 4'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (press_begin) begin
            first_q      <= botoes_q;
            hold         <= 8'd1;
            pressed_note <= lowest;
        end else if (active && botoes_q != 12'd0 && hold != 8'hff) begin
            hold <= hold + 8'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            botoes_q   <= '0;
            active     <= 1'b0;
            varied     <= 1'b0;
            press_done <= 1'b0;
            note_ok    <= 1'b0;
            timing_ok  <= 1'b0;
        end else begin
            botoes_q   <= botoes;
            press_done <= 1'b0;
            if (!listen) begin
                active <= 1'b0;
            end else if (press_begin) begin
                active <= 1'b1;
                varied <= 1'b0;
            end else if (active) begin
                if (botoes_q != 12'd0) begin
                    if (botoes_q != first_q) begin
                        varied <= 1'b1;
                    end
                end else begin
                    // Release; the expected note is read only now,
                    // after the address has settled on this note
                    active     <= 1'b0;
                    press_done <= 1'b1;
                    note_ok    <= !varied && (first_q == expected_onehot);
                    timing_ok  <= (hold + 8'(tol_cycles) >= target) &&
                                  (hold <= target + 8'(tol_cycles));
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_melody_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_melody_game import game_pkg::*, note_pkg::*; ();

    localparam int num_games  = 6;
    // Six games of eight rounds with retries, with a wide margin
    localparam int max_cycles = 400000;

    localparam int flag_lit     = 0;
    localparam int flag_no_turn = 1;
    localparam int flag_lost    = 2;
    localparam int flag_won     = 3;

    localparam int res_next = 0;
    localparam int res_won  = 1;
    localparam int res_lost = 2;

    logic        clock;
    logic        reset;
    logic        iniciar;
    logic        tentar_dnv;
    logic [11:0] botoes;
    logic        ganhou;
    logic        perdeu;
    logic        vez_jogador;
    logic [11:0] leds;
    logic        pulso_buzzer;
    logic [6:0]  db_round;
    logic [6:0]  db_state;
    logic [6:0]  db_note;

    logic [31:0] rng_state;
    int          cycle_count;
    int          round;
    int          games_done;
    int          outcome;

    melody_game i_dut (
        .clock        ( clock        ),
        .reset        ( reset        ),
        .iniciar      ( iniciar      ),
        .tentar_dnv   ( tentar_dnv   ),
        .botoes       ( botoes       ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       ),
        .vez_jogador  ( vez_jogador  ),
        .leds         ( leds         ),
        .pulso_buzzer ( pulso_buzzer ),
        .db_round     ( db_round     ),
        .db_state     ( db_state     ),
        .db_note      ( db_note      )
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("%0d ns: cycle limit reached before all games ended", $time);
        $display("Simulation failed");
        $fatal(1, "cycle limit reached");
    end

    // LCG keeping the upper bits
    function automatic int next_random(input int range);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'(rng_state[30:8]) % range;
    endfunction

    // Segments gfedcba with lit high
    function automatic logic [6:0] seg_pattern(input int digit);
        case (digit)
            0:       return 7'b0111111;
            1:       return 7'b0000110;
            2:       return 7'b1011011;
            3:       return 7'b1001111;
            4:       return 7'b1100110;
            5:       return 7'b1101101;
            6:       return 7'b1111101;
            7:       return 7'b0000111;
            8:       return 7'b1111111;
            9:       return 7'b1101111;
            10:      return 7'b1110111;
            default: return 7'b1111100;
        endcase
    endfunction

    function automatic int lowest_button(input logic [11:0] pattern);
        for (int i = 0; i < 12; i++) begin
            if (pattern[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic logic flag_value(input int which);
        case (which)
            flag_lit:     return leds != 12'd0;
            flag_no_turn: return !vez_jogador;
            flag_lost:    return perdeu;
            default:      return ganhou;
        endcase
    endfunction

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s: got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%0d ns: %s", $time, why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic wait_for(input int which, input int limit, input string what);
        int n;
        n = 0;
        while (!flag_value(which)) begin
            if (n == limit) begin
                stop_run({"gave up waiting for ", what});
            end
            tick();
            n++;
        end
    endtask

    task automatic send_pulse(input logic retry);
        if (retry) begin
            tentar_dnv = 1'b1;
        end else begin
            iniciar = 1'b1;
        end
        tick();
        iniciar    = 1'b0;
        tentar_dnv = 1'b0;
    endtask

    task automatic check_loss();
        check_value(32'(perdeu), 32'd1, "perdeu on loss");
        check_value(32'(ganhou), 32'd0, "ganhou on loss");
        check_value(32'(vez_jogador), 32'd0, "vez_jogador on loss");
    endtask

    task automatic check_playback(input int r);
        int         lit_len;
        int         dark;
        int         k;
        note_t      n;
        logic [7:0] hp;
        logic       buzz_exp;
        logic       gap_ok;
        wait_for(flag_lit, gap_cycles + 4, "first note of playback");
        check_value(32'(db_round), 32'(seg_pattern(r)), "db_round at playback");
        check_value(32'(ganhou), 32'd0, "ganhou at playback");
        check_value(32'(perdeu), 32'd0, "perdeu at playback");
        for (int i = 0; i < r; i++) begin
            n       = melody_note[i];
            hp      = half_period[n];
            lit_len = int'(melody_dur[i]) * beat_cycles;
            k       = 0;
            while (leds != 12'd0 && k <= lit_len) begin
                // Buzzer starts high and flips every half-period
                buzz_exp = ((k / int'(hp)) % 2) == 0;
                check_value(32'(leds), 32'(12'd1 << n), "played note");
                check_value(32'(pulso_buzzer), 32'(buzz_exp), "buzzer while lit");
                check_value(32'(vez_jogador), 32'd0, "vez_jogador during playback");
                tick();
                k++;
            end
            check_value(32'(k), 32'(lit_len), "lit length of note");
            dark = 0;
            while (leds == 12'd0 && !vez_jogador && dark <= gap_cycles + 3) begin
                check_value(32'(pulso_buzzer), 32'd0, "buzzer in gap");
                tick();
                dark++;
            end
            if (i < r - 1) begin
                gap_ok = (dark >= gap_cycles) && (dark <= gap_cycles + 3);
                check_value(32'(gap_ok), 32'd1, "gap between notes in range");
            end else begin
                gap_ok = (dark >= gap_cycles) && (dark <= gap_cycles + 2);
                check_value(32'(gap_ok), 32'd1, "gap before player turn in range");
                check_value(32'(vez_jogador), 32'd1, "vez_jogador after playback");
            end
        end
    endtask

    task automatic play_turn(input int r, output int result);
        int          choice;
        int          hold;
        int          target;
        int          wrong;
        int          pause;
        int          idle;
        logic [11:0] pattern;
        note_t       n;
        logic        good;
        result = res_next;
        // Turn entry or the last release starts the idle count
        idle   = 0;
        for (int j = 0; j < r; j++) begin
            n      = melody_note[j];
            target = int'(melody_dur[j]) * beat_cycles;
            pause  = 4 + next_random(6);
            repeat (pause) begin
                check_value(32'(vez_jogador), 32'd1, "vez_jogador during turn");
                check_value(32'(perdeu), 32'd0, "perdeu during turn");
                tick();
                idle++;
            end
            choice  = next_random(100);
            wrong   = (int'(n) + 1 + next_random(11)) % num_notes;
            hold    = target - tol_cycles + next_random(2 * tol_cycles + 1);
            pattern = 12'd1 << n;
            good    = 1'b0;
            if (choice >= 97) begin
                // Player never presses
                while (!perdeu) begin
                    if (idle == timeout_cycles + 8) begin
                        stop_run("no loss after the turn timeout");
                    end
                    tick();
                    idle++;
                end
                check_value(32'(idle >= timeout_cycles), 32'd1,
                            "loss only after the turn timeout");
                check_loss();
                result = res_lost;
                return;
            end
            if (choice < 80) begin
                good = 1'b1;
            end else if (choice < 87) begin
                pattern = 12'd1 << wrong;
            end else if (choice < 94) begin
                if (next_random(2) == 0) begin
                    hold = 1 + next_random(target - tol_cycles - 1);
                end else begin
                    hold = target + tol_cycles + 1 + next_random(8);
                end
            end else begin
                pattern = pattern | (12'd1 << wrong);
            end
            botoes = pattern;
            repeat (hold) tick();
            botoes = 12'd0;
            idle   = 0;
            repeat (3) begin
                tick();
                idle++;
            end
            check_value(32'(db_note), 32'(seg_pattern(lowest_button(pattern))),
                        "db_note after press");
            if (!good) begin
                wait_for(flag_lost, 8, "loss after bad press");
                check_loss();
                result = res_lost;
                return;
            end
        end
        if (r == num_rounds) begin
            wait_for(flag_won, 8, "win after last round");
            check_value(32'(perdeu), 32'd0, "perdeu on win");
            check_value(32'(vez_jogador), 32'd0, "vez_jogador on win");
            result = res_won;
        end else begin
            wait_for(flag_no_turn, 8, "end of player turn");
            check_value(32'(perdeu), 32'd0, "perdeu after round");
            check_value(32'(ganhou), 32'd0, "ganhou after round");
        end
    endtask

    initial begin
        rng_state  = 32'h84d8_4db4;
        reset      = 1'b1;
        iniciar    = 1'b0;
        tentar_dnv = 1'b0;
        botoes     = 12'd0;
        games_done = 0;
        repeat (4) tick();
        reset = 1'b0;

        check_value(32'(ganhou), 32'd0, "ganhou after reset");
        check_value(32'(perdeu), 32'd0, "perdeu after reset");
        check_value(32'(vez_jogador), 32'd0, "vez_jogador after reset");
        check_value(32'(leds), 32'd0, "leds after reset");
        check_value(32'(pulso_buzzer), 32'd0, "pulso_buzzer after reset");
        check_value(32'(db_round), 32'(seg_pattern(0)), "db_round after reset");
        check_value(32'(db_state), 32'(seg_pattern(int'(st_idle))), "db_state after reset");

        send_pulse(1'b0);
        round = 1;
        while (games_done < num_games) begin
            check_playback(round);
            play_turn(round, outcome);
            if (outcome == res_next) begin
                round++;
            end else if (outcome == res_won) begin
                games_done++;
                repeat (3 + next_random(10)) begin
                    check_value(32'(ganhou), 32'd1, "ganhou held");
                    tick();
                end
                send_pulse(1'b0);
                round = 1;
            end else begin
                repeat (2 + next_random(5)) begin
                    check_value(32'(perdeu), 32'd1, "perdeu held");
                    tick();
                end
                // Restart only from early rounds, so games still reach the end
                if (round < 4 && next_random(4) == 0) begin
                    send_pulse(1'b0);
                    round = 1;
                end else begin
                    send_pulse(1'b1);
                end
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
